/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_lpif_lsm
FILELIST = tb.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: simulate clean

simulate:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* hdl/lpif_lsm.sv */
/*
  Top level of the LPIF adapter link state machine.
  Ties the event decoder, the link FSM, the clock-gate exit and stall
  handshakes and the wake synchronizer to the plain LPIF ports.
*/

`timescale 1ns/1ps

module lpif_lsm
(
  input  logic                          lclk,
  input  logic                          rst_n,
  input  logic [3:0]                    lp_state_req,
  input  logic [3:0]                    ustrm_state,
  input  logic                          ctl_link_up,
  input  logic                          ctl_phy_err,
  input  logic                          lp_exit_cg_ack,
  input  logic                          lp_stallack,
  input  logic                          lp_wake_req,
  output logic [3:0]                    pl_state_sts,
  output logic                          lsm_state_active,
  output logic                          pl_exit_cg_req,
  output logic                          pl_stallreq,
  output logic                          pl_wake_ack,
  output logic                          pl_phyinl1,
  output logic                          pl_phyinrecenter,
  output logic                          pl_lnk_up,
  output logic [3:0]                    lsm_dstrm_state,
  output logic [lsm_pkg::LNK_CFG_W-1:0] lsm_lnk_cfg,
  output logic [lsm_pkg::SPEED_W-1:0]   lsm_speedmode
);

  logic cg_start;
  logic stall_start;

  lsm_evt_if evt ();

  assign lsm_dstrm_state = evt.dstrm;

  lsm_event_decode event_decode_inst
  (
    .lclk         (lclk),
    .rst_n        (rst_n),
    .lp_state_req (lsm_pkg::state_req_e'(lp_state_req)),
    .ustrm_state  (lsm_pkg::sb_msg_e'(ustrm_state)),
    .evt          (evt)
  );

  lsm_fsm fsm_inst
  (
    .lclk          (lclk),
    .rst_n         (rst_n),
    .evt           (evt),
    .ctl_link_up   (ctl_link_up),
    .ctl_phy_err   (ctl_phy_err),
    .cg_req        (pl_exit_cg_req),
    .cg_ack        (lp_exit_cg_ack),
    .stall_req     (pl_stallreq),
    .stall_ack     (lp_stallack),
    .cg_start      (cg_start),
    .stall_start   (stall_start),
    .state_sts     (pl_state_sts),
    .state_active  (lsm_state_active),
    .phyinl1       (pl_phyinl1),
    .phyinrecenter (pl_phyinrecenter),
    .lnk_up        (pl_lnk_up),
    .lnk_cfg       (lsm_lnk_cfg),
    .speedmode     (lsm_speedmode)
  );

  // Clock-gate exit toward the phy
  lsm_phy_handshake cg_hs
  (
    .lclk  (lclk),
    .rst_n (rst_n),
    .start (cg_start),
    .ack   (lp_exit_cg_ack),
    .req   (pl_exit_cg_req)
  );

  // Stall on every exit from active
  lsm_phy_handshake stall_hs
  (
    .lclk  (lclk),
    .rst_n (rst_n),
    .start (stall_start),
    .ack   (lp_stallack),
    .req   (pl_stallreq)
  );

  lsm_wake_sync wake_sync_inst
  (
    .lclk     (lclk),
    .rst_n    (rst_n),
    .wake_req (lp_wake_req),
    .wake_ack (pl_wake_ack)
  );

endmodule

/* hdl/lsm_event_decode.sv */
/*
  Event decoder in front of the link FSM.
  Registers the local state request and flags each new non-nop request
  until the FSM clears it. Also decodes the upstream sideband message
  against the request the FSM sends downstream.
*/

`timescale 1ns/1ps

module lsm_event_decode
(
  input  logic                lclk,
  input  logic                rst_n,
  input  lsm_pkg::state_req_e lp_state_req,
  input  lsm_pkg::sb_msg_e    ustrm_state,
  lsm_evt_if.decoder          evt
);

  logic req_new;
  logic ack_d;

  // evt.state_req holds the request of one cycle earlier
  assign req_new = (lp_state_req != evt.state_req) &&
                   (lp_state_req != lsm_pkg::REQ_NOP);

  // Partner status that answers our pending request
  always_comb
  begin
    case (evt.dstrm)
      lsm_pkg::SB_L1_REQ:
        ack_d = (ustrm_state == lsm_pkg::SB_L1_STS);
      lsm_pkg::SB_ACTIVE_REQ:
        ack_d = (ustrm_state == lsm_pkg::SB_ACTIVE_STS);
      lsm_pkg::SB_LINK_RESET_REQ:
        ack_d = (ustrm_state == lsm_pkg::SB_LINK_RESET_STS);
      default:
        ack_d = 1'b0;
    endcase
  end

  always_ff @(posedge lclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      evt.state_req     <= lsm_pkg::REQ_NOP;
      evt.req_change    <= 1'b0;
      evt.sb_ack        <= 1'b0;
      evt.sb_active_req <= 1'b0;
    end
    else
    begin
      evt.state_req     <= lp_state_req;
      // Sticky until taken; a request arriving with the clear survives
      evt.req_change    <= (evt.req_change && !evt.req_change_clr) || req_new;
      evt.sb_ack        <= ack_d;
      evt.sb_active_req <= (ustrm_state == lsm_pkg::SB_ACTIVE_REQ);
    end
  end

  // FSM only takes a request that is actually pending
  clr_needs_change: assert property (@(posedge lclk) disable iff (!rst_n)
    evt.req_change_clr |-> evt.req_change);

endmodule

/* hdl/lsm_evt_if.sv */
/*
  Event bundle between the event decoder and the link FSM.
  The decoder side carries the registered request and sideband events,
  the FSM side returns the change clear and its downstream message.
*/

`timescale 1ns/1ps

interface lsm_evt_if;

  lsm_pkg::state_req_e state_req;
  logic                req_change;
  logic                sb_ack;
  logic                sb_active_req;
  logic                req_change_clr;
  lsm_pkg::sb_msg_e    dstrm;

  modport decoder (
    output state_req, req_change, sb_ack, sb_active_req,
    input  req_change_clr, dstrm
  );

  modport fsm (
    input  state_req, req_change, sb_ack, sb_active_req,
    output req_change_clr, dstrm
  );

endinterface

/* hdl/lsm_fsm.sv */
/*
  LPIF link state machine with registered status outputs.
  Brings the link up through one retrain, handles local L1 entry and
  exit, local link reset and the sticky physical error. Partner
  agreement goes through the sideband, phy handshakes through the
  cg and stall controllers.
*/

`timescale 1ns/1ps

module lsm_fsm
(
  input  logic                          lclk,
  input  logic                          rst_n,
  lsm_evt_if.fsm                        evt,
  input  logic                          ctl_link_up,
  input  logic                          ctl_phy_err,
  input  logic                          cg_req,
  input  logic                          cg_ack,
  input  logic                          stall_req,
  input  logic                          stall_ack,
  output logic                          cg_start,
  output logic                          stall_start,
  output lsm_pkg::state_sts_e           state_sts,
  output logic                          state_active,
  output logic                          phyinl1,
  output logic                          phyinrecenter,
  output logic                          lnk_up,
  output logic [lsm_pkg::LNK_CFG_W-1:0] lnk_cfg,
  output logic [lsm_pkg::SPEED_W-1:0]   speedmode
);

  lsm_pkg::lsm_state_e          state_q;
  lsm_pkg::lsm_state_e          state_d;
  lsm_pkg::lsm_state_e          ret_q;
  lsm_pkg::lsm_state_e          ret_d;
  lsm_pkg::state_sts_e          sts_d;
  lsm_pkg::sb_msg_e             dstrm_d;
  logic                         coldstart_q;
  logic                         coldstart_d;
  logic                         exit_lp_q;
  logic                         exit_lp_d;
  logic                         lnk_up_d;
  logic                         phyinl1_d;
  logic                         recenter_d;
  logic [lsm_pkg::LNK_CFG_W-1:0] cfg_d;
  logic [lsm_pkg::SPEED_W-1:0]   speed_d;
  logic                         req_active;
  logic                         req_idle_l1;
  logic                         req_link_reset;
  logic                         req_retrain;
  logic                         exit_active;

  assign req_active     = (evt.state_req == lsm_pkg::REQ_ACTIVE);
  assign req_idle_l1    = (evt.state_req == lsm_pkg::REQ_IDLE_L1);
  assign req_link_reset = (evt.state_req == lsm_pkg::REQ_LINK_RESET);
  assign req_retrain    = (evt.state_req == lsm_pkg::REQ_RETRAIN);

  // Cold start always leaves active once for the first retrain
  assign exit_active = coldstart_q || (evt.req_change && (req_idle_l1 || req_link_reset));

  assign state_active = (state_sts == lsm_pkg::STS_ACTIVE);

  ////////////////////
  // Next state
  ////////////////////

  always_comb
  begin
    state_d            = state_q;
    ret_d              = ret_q;
    sts_d              = state_sts;
    dstrm_d            = evt.dstrm;
    lnk_up_d           = lnk_up;
    cfg_d              = lnk_cfg;
    speed_d            = speedmode;
    coldstart_d        = coldstart_q;
    exit_lp_d          = exit_lp_q;
    phyinl1_d          = 1'b0;
    recenter_d         = 1'b0;
    cg_start           = 1'b0;
    stall_start        = 1'b0;
    evt.req_change_clr = 1'b0;
    // Physical error wins over everything and never clears
    if (ctl_phy_err)
    begin
      sts_d   = lsm_pkg::STS_LINK_ERROR;
      state_d = lsm_pkg::LSM_LINK_ERROR;
      // Error message goes out one edge after the status
      if (state_q == lsm_pkg::LSM_LINK_ERROR)
        dstrm_d = lsm_pkg::SB_LINK_ERROR;
    end
    else
    begin
      case (state_q)
        lsm_pkg::LSM_RESET:
        begin
          sts_d = lsm_pkg::STS_RESET;
          if (ctl_link_up)
            state_d = evt.sb_active_req ? lsm_pkg::LSM_RESET_ACK : lsm_pkg::LSM_RESET_UP;
        end
        lsm_pkg::LSM_RESET_ACK:
        begin
          // Answer the partner, then wait for it to let go
          dstrm_d = lsm_pkg::SB_ACTIVE_STS;
          if (!evt.sb_active_req)
            state_d = lsm_pkg::LSM_RESET_UP;
        end
        lsm_pkg::LSM_RESET_UP:
        begin
          lnk_up_d = 1'b1;
          dstrm_d  = lsm_pkg::SB_NULL;
          if (coldstart_q || evt.sb_active_req)
          begin
            cg_start = 1'b1;
            state_d  = lsm_pkg::LSM_ACTIVE_ENTER;
          end
          else if (evt.req_change && req_active)
          begin
            evt.req_change_clr = 1'b1;
            state_d            = lsm_pkg::LSM_ACTIVE_REQ;
          end
        end
        lsm_pkg::LSM_ACTIVE_REQ:
        begin
          dstrm_d = lsm_pkg::SB_ACTIVE_REQ;
          ret_d   = lsm_pkg::LSM_ACTIVE_ENTER;
          state_d = lsm_pkg::LSM_SB_ACK;
        end
        lsm_pkg::LSM_ACTIVE_ENTER:
        begin
          if (cg_req && cg_ack)
          begin
            sts_d   = lsm_pkg::STS_ACTIVE;
            dstrm_d = lsm_pkg::SB_ACTIVE_STS;
            state_d = lsm_pkg::LSM_ACTIVE;
          end
        end
        lsm_pkg::LSM_ACTIVE:
        begin
          if (exit_active && !stall_req && !stall_ack)
          begin
            evt.req_change_clr = evt.req_change;
            stall_start        = 1'b1;
            state_d            = lsm_pkg::LSM_ACTIVE_STALL;
          end
        end
        lsm_pkg::LSM_ACTIVE_STALL:
        begin
          if (stall_req && stall_ack)
          begin
            if (coldstart_q)
            begin
              sts_d   = lsm_pkg::STS_RETRAIN;
              dstrm_d = lsm_pkg::SB_RETRAIN_STS;
              state_d = lsm_pkg::LSM_RETRAIN_A;
            end
            else if (req_idle_l1)
            begin
              dstrm_d = lsm_pkg::SB_L1_REQ;
              ret_d   = lsm_pkg::LSM_IDLE_L1;
              state_d = lsm_pkg::LSM_SB_ACK;
            end
            else if (req_link_reset)
            begin
              dstrm_d = lsm_pkg::SB_LINK_RESET_REQ;
              ret_d   = lsm_pkg::LSM_LINK_RESET_WAIT;
              state_d = lsm_pkg::LSM_SB_ACK;
            end
            else
              state_d = lsm_pkg::LSM_ACTIVE;
          end
        end
        lsm_pkg::LSM_IDLE_L1:
        begin
          sts_d     = lsm_pkg::STS_IDLE_L1;
          dstrm_d   = lsm_pkg::SB_L1_STS;
          phyinl1_d = 1'b1;
          if (evt.req_change && (req_active || req_retrain))
          begin
            // Wake up goes through a retrain
            evt.req_change_clr = 1'b1;
            exit_lp_d          = 1'b1;
            dstrm_d            = lsm_pkg::SB_ACTIVE_REQ;
            ret_d              = lsm_pkg::LSM_RETRAIN_A;
            state_d            = lsm_pkg::LSM_SB_ACK;
          end
          else if (evt.req_change && req_link_reset)
          begin
            evt.req_change_clr = 1'b1;
            dstrm_d            = lsm_pkg::SB_LINK_RESET_REQ;
            ret_d              = lsm_pkg::LSM_LINK_RESET_WAIT;
            state_d            = lsm_pkg::LSM_SB_ACK;
          end
        end
        lsm_pkg::LSM_LINK_RESET_WAIT:
        begin
          if (evt.sb_ack)
          begin
            sts_d    = lsm_pkg::STS_LINK_RESET;
            lnk_up_d = 1'b0;
            state_d  = lsm_pkg::LSM_LINK_RESET;
          end
        end
        lsm_pkg::LSM_LINK_RESET:
        begin
          dstrm_d = lsm_pkg::SB_LINK_RESET_STS;
          if (evt.sb_active_req)
            state_d = lsm_pkg::LSM_RESET;
          else if (evt.req_change && req_active)
          begin
            evt.req_change_clr = 1'b1;
            dstrm_d            = lsm_pkg::SB_ACTIVE_REQ;
            ret_d              = lsm_pkg::LSM_RESET;
            state_d            = lsm_pkg::LSM_SB_ACK;
          end
        end
        lsm_pkg::LSM_LINK_ERROR:
          dstrm_d = lsm_pkg::SB_LINK_ERROR;
        lsm_pkg::LSM_RETRAIN_A:
        begin
          dstrm_d = lsm_pkg::SB_RETRAIN_STS;
          state_d = lsm_pkg::LSM_RETRAIN_B;
        end
        lsm_pkg::LSM_RETRAIN_B:
          state_d = lsm_pkg::LSM_RETRAIN_C;
        lsm_pkg::LSM_RETRAIN_C:
        begin
          // Previous clock-gate exchange must be fully closed
          if ((coldstart_q || exit_lp_q) && !cg_req && !cg_ack)
          begin
            sts_d   = lsm_pkg::STS_RETRAIN;
            state_d = lsm_pkg::LSM_RETRAIN;
          end
        end
        lsm_pkg::LSM_RETRAIN:
        begin
          cfg_d      = lsm_pkg::LNK_CFG_X16;
          speed_d    = lsm_pkg::SPEED_GEN5;
          recenter_d = 1'b1;
          dstrm_d    = lsm_pkg::SB_RETRAIN_STS;
          if (coldstart_q || exit_lp_q || (evt.req_change && req_active))
          begin
            evt.req_change_clr = evt.req_change;
            coldstart_d        = 1'b0;
            exit_lp_d          = 1'b0;
            cg_start           = 1'b1;
            state_d            = lsm_pkg::LSM_ACTIVE_ENTER;
          end
        end
        lsm_pkg::LSM_SB_ACK:
        begin
          if (evt.sb_ack)
          begin
            cg_start = (ret_q == lsm_pkg::LSM_ACTIVE_ENTER);
            state_d  = ret_q;
          end
        end
        default:
          state_d = lsm_pkg::LSM_RESET;
      endcase
    end
  end

  ////////////////////
  // State and outputs
  ////////////////////

  always_ff @(posedge lclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q       <= lsm_pkg::LSM_RESET;
      ret_q         <= lsm_pkg::LSM_RESET;
      coldstart_q   <= 1'b1;
      exit_lp_q     <= 1'b0;
      state_sts     <= lsm_pkg::STS_RESET;
      evt.dstrm     <= lsm_pkg::SB_NULL;
      lnk_up        <= 1'b0;
      phyinl1       <= 1'b0;
      phyinrecenter <= 1'b0;
      lnk_cfg       <= lsm_pkg::LNK_CFG_X1;
      speedmode     <= lsm_pkg::SPEED_GEN1;
    end
    else
    begin
      state_q       <= state_d;
      ret_q         <= ret_d;
      coldstart_q   <= coldstart_d;
      exit_lp_q     <= exit_lp_d;
      state_sts     <= sts_d;
      evt.dstrm     <= dstrm_d;
      lnk_up        <= lnk_up_d;
      phyinl1       <= phyinl1_d;
      phyinrecenter <= recenter_d;
      lnk_cfg       <= cfg_d;
      speedmode     <= speed_d;
    end
  end

  sts_legal: assert property (@(posedge lclk) disable iff (!rst_n)
    state_sts inside {lsm_pkg::STS_RESET, lsm_pkg::STS_ACTIVE, lsm_pkg::STS_IDLE_L1,
                      lsm_pkg::STS_LINK_RESET, lsm_pkg::STS_LINK_ERROR,
                      lsm_pkg::STS_RETRAIN});

  l1_only_in_idle: assert property (@(posedge lclk) disable iff (!rst_n)
    phyinl1 |-> (state_sts == lsm_pkg::STS_IDLE_L1));

endmodule

/* hdl/lsm_phy_handshake.sv */
/*
  Request/acknowledge controller toward the physical layer.
  A start pulse raises req on the next edge; req drops the cycle
  after the registered ack is seen. Used for clock-gate exit and stall.
*/

`timescale 1ns/1ps

module lsm_phy_handshake
(
  input  logic lclk,
  input  logic rst_n,
  input  logic start,
  input  logic ack,
  output logic req
);

  logic ack_q;

  always_ff @(posedge lclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      req   <= 1'b0;
      ack_q <= 1'b0;
    end
    else
    begin
      ack_q <= ack;
      if (start)
        req <= 1'b1;
      else if (ack_q)
        req <= 1'b0;
    end
  end

  // Next start only once the previous exchange is over
  start_when_idle: assert property (@(posedge lclk) disable iff (!rst_n)
    start |-> !req);

endmodule

/* hdl/lsm_pkg.sv */
/*
  Shared types and constants of the LPIF link state machine.
  Request, status and sideband encodings match the LPIF fields.
  RTL and testbench refer to these by scoped name.
*/

package lsm_pkg;

  ////////////////////
  // Widths and codes
  ////////////////////

  localparam int LNK_CFG_W = 3;
  localparam int SPEED_W = 3;

  localparam logic [LNK_CFG_W-1:0] LNK_CFG_X1 = 3'd0;
  localparam logic [LNK_CFG_W-1:0] LNK_CFG_X16 = 3'd5;

  localparam logic [SPEED_W-1:0] SPEED_GEN1 = 3'd0;
  localparam logic [SPEED_W-1:0] SPEED_GEN5 = 3'd4;

  // Flops in the wake request synchronizer
  localparam int WAKE_SYNC_STAGES = 2;

  ////////////////////
  // Encodings
  ////////////////////

  // Local state request on lp_state_req
  typedef enum logic [3:0] {
    REQ_NOP        = 4'h0,
    REQ_ACTIVE     = 4'h1,
    REQ_IDLE_L1    = 4'h4,
    REQ_LINK_RESET = 4'h9,
    REQ_RETRAIN    = 4'hB
  } state_req_e;

  // Reported status on pl_state_sts
  typedef enum logic [3:0] {
    STS_RESET      = 4'h0,
    STS_ACTIVE     = 4'h1,
    STS_IDLE_L1    = 4'h4,
    STS_LINK_RESET = 4'h9,
    STS_LINK_ERROR = 4'hA,
    STS_RETRAIN    = 4'hB
  } state_sts_e;

  // Sideband messages, both directions
  typedef enum logic [3:0] {
    SB_NULL           = 4'h0,
    SB_L1_REQ         = 4'h1,
    SB_L1_STS         = 4'h2,
    SB_ACTIVE_REQ     = 4'h3,
    SB_ACTIVE_STS     = 4'h4,
    SB_LINK_ERROR     = 4'h5,
    SB_LINK_RESET_REQ = 4'h8,
    SB_LINK_RESET_STS = 4'h9,
    SB_RETRAIN_STS    = 4'hB
  } sb_msg_e;

  typedef enum logic [4:0] {
    LSM_RESET           = 5'h00,
    LSM_RESET_ACK       = 5'h01,
    LSM_RESET_UP        = 5'h02,
    LSM_ACTIVE_ENTER    = 5'h03,
    LSM_ACTIVE_REQ      = 5'h04,
    LSM_ACTIVE          = 5'h05,
    LSM_ACTIVE_STALL    = 5'h06,
    LSM_IDLE_L1         = 5'h07,
    LSM_LINK_RESET_WAIT = 5'h08,
    LSM_LINK_RESET      = 5'h09,
    LSM_LINK_ERROR      = 5'h0A,
    LSM_RETRAIN_A       = 5'h0B,
    LSM_RETRAIN_B       = 5'h0C,
    LSM_RETRAIN_C       = 5'h0D,
    LSM_RETRAIN         = 5'h0E,
    LSM_SB_ACK          = 5'h0F
  } lsm_state_e;

endpackage

/* hdl/lsm_wake_sync.sv */
/*
  Wake request synchronizer and acknowledge.
  The request passes a reset-to-0 flop chain, then a registered ack
  follows it up and down.
*/

`timescale 1ns/1ps

module lsm_wake_sync
(
  input  logic lclk,
  input  logic rst_n,
  input  logic wake_req,
  output logic wake_ack
);

  logic [lsm_pkg::WAKE_SYNC_STAGES-1:0] sync_q;

  always_ff @(posedge lclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sync_q   <= '0;
      wake_ack <= 1'b0;
    end
    else
    begin
      sync_q[0] <= wake_req;
      for (int i = 1; i < lsm_pkg::WAKE_SYNC_STAGES; i++)
        sync_q[i] <= sync_q[i-1];
      wake_ack <= sync_q[lsm_pkg::WAKE_SYNC_STAGES-1];
    end
  end

endmodule

/* tb.f */
hdl/lsm_pkg.sv
hdl/lsm_evt_if.sv
hdl/lsm_event_decode.sv
hdl/lsm_phy_handshake.sv
hdl/lsm_wake_sync.sv
hdl/lsm_fsm.sv
hdl/lpif_lsm.sv
test/lsm_phy_model.sv
test/tb_lpif_lsm.sv

/* test/lsm_phy_model.sv */
/*
  Model of the physical layer and the remote sideband partner.
  Answers the clock-gate exit and stall requests after a random delay
  and answers each downstream request message with its status, or
  holds the active request while partner_act is high.
*/

`timescale 1ns/1ps

module lsm_phy_model
(
  input  logic       lclk,
  input  logic       rst_n,
  input  logic       cg_req,
  input  logic       stall_req,
  input  logic [3:0] dstrm,
  input  logic       partner_act,
  output logic       cg_ack,
  output logic       stall_ack,
  output logic [3:0] ustrm
);

  logic [31:0] rng;
  logic [1:0]  req_v;
  logic [1:0]  ack_v;
  logic [1:0]  busy;
  // Two 2-bit delay counters with cg in the low half
  logic [3:0]  wait_cnt;

  assign req_v     = {stall_req, cg_req};
  assign cg_ack    = ack_v[0];
  assign stall_ack = ack_v[1];

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Status the partner returns for a request message
  function automatic logic [3:0] partner_answer(input logic [3:0] msg);
    case (msg)
      lsm_pkg::SB_L1_REQ:         return lsm_pkg::SB_L1_STS;
      lsm_pkg::SB_ACTIVE_REQ:     return lsm_pkg::SB_ACTIVE_STS;
      lsm_pkg::SB_LINK_RESET_REQ: return lsm_pkg::SB_LINK_RESET_STS;
      default:                    return lsm_pkg::SB_NULL;
    endcase
  endfunction

  always @(posedge lclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rng      <= 32'd68763;
      ack_v    <= '0;
      busy     <= '0;
      wait_cnt <= '0;
      ustrm    <= lsm_pkg::SB_NULL;
    end
    else
    begin
      rng   <= xorshift32(rng);
      ustrm <= partner_act ? lsm_pkg::SB_ACTIVE_REQ : partner_answer(dstrm);
      for (int i = 0; i < 2; i++)
      begin
        if (!req_v[i])
        begin
          ack_v[i] <= 1'b0;
          busy[i]  <= 1'b0;
        end
        else if (!busy[i])
        begin
          // New request, wait 0 to 3 cycles
          busy[i]            <= 1'b1;
          wait_cnt[2*i +: 2] <= rng[2*i +: 2];
          ack_v[i]           <= (rng[2*i +: 2] == 2'd0);
        end
        else if (wait_cnt[2*i +: 2] != 2'd0)
        begin
          wait_cnt[2*i +: 2] <= wait_cnt[2*i +: 2] - 2'd1;
          ack_v[i]           <= (wait_cnt[2*i +: 2] == 2'd1);
        end
      end
    end
  end

endmodule

/* test/tb_lpif_lsm.sv */
/*
  Testbench for the LPIF link state machine.
  Applies a table of requests and partner modes, waits for each
  expected status and checks the link outputs. Ends with the wake
  acknowledge latency. A watchdog bounds the run.
*/

`timescale 1ns/1ps

module tb_lpif_lsm;

  localparam int CLK_PERIOD = 40;
  localparam int NUM_ROWS = 9;
  localparam int ROW_TIMEOUT = 60;
  localparam int HOLD_MAX = 20;
  localparam int WATCHDOG_CYCLES = NUM_ROWS * (ROW_TIMEOUT + HOLD_MAX + 3) + 60;

  typedef struct packed {
    logic [3:0]                    req;
    logic                          link_up;
    logic                          phy_err;
    logic                          partner_act;
    logic [3:0]                    sts;
    logic [3:0]                    dstrm;
    logic                          lnk_up;
    logic                          phyinl1;
    logic [lsm_pkg::LNK_CFG_W-1:0] cfg;
    logic [lsm_pkg::SPEED_W-1:0]   speed;
    int                            lat;
    int                            hold;
  } row_t;

  logic                          lclk;
  logic                          rst_n;
  logic [3:0]                    lp_state_req;
  logic [3:0]                    ustrm_state;
  logic                          ctl_link_up;
  logic                          ctl_phy_err;
  logic                          lp_exit_cg_ack;
  logic                          lp_stallack;
  logic                          lp_wake_req;
  logic                          partner_act;
  logic [3:0]                    pl_state_sts;
  logic                          lsm_state_active;
  logic                          pl_exit_cg_req;
  logic                          pl_stallreq;
  logic                          pl_wake_ack;
  logic                          pl_phyinl1;
  logic                          pl_phyinrecenter;
  logic                          pl_lnk_up;
  logic [3:0]                    lsm_dstrm_state;
  logic [lsm_pkg::LNK_CFG_W-1:0] lsm_lnk_cfg;
  logic [lsm_pkg::SPEED_W-1:0]   lsm_speedmode;

  row_t rows [NUM_ROWS];

  lpif_lsm lpif_lsm_inst
  (
    .lclk             (lclk),
    .rst_n            (rst_n),
    .lp_state_req     (lp_state_req),
    .ustrm_state      (ustrm_state),
    .ctl_link_up      (ctl_link_up),
    .ctl_phy_err      (ctl_phy_err),
    .lp_exit_cg_ack   (lp_exit_cg_ack),
    .lp_stallack      (lp_stallack),
    .lp_wake_req      (lp_wake_req),
    .pl_state_sts     (pl_state_sts),
    .lsm_state_active (lsm_state_active),
    .pl_exit_cg_req   (pl_exit_cg_req),
    .pl_stallreq      (pl_stallreq),
    .pl_wake_ack      (pl_wake_ack),
    .pl_phyinl1       (pl_phyinl1),
    .pl_phyinrecenter (pl_phyinrecenter),
    .pl_lnk_up        (pl_lnk_up),
    .lsm_dstrm_state  (lsm_dstrm_state),
    .lsm_lnk_cfg      (lsm_lnk_cfg),
    .lsm_speedmode    (lsm_speedmode)
  );

  lsm_phy_model phy_inst
  (
    .lclk        (lclk),
    .rst_n       (rst_n),
    .cg_req      (pl_exit_cg_req),
    .stall_req   (pl_stallreq),
    .dstrm       (lsm_dstrm_state),
    .partner_act (partner_act),
    .cg_ack      (lp_exit_cg_ack),
    .stall_ack   (lp_stallack),
    .ustrm       (ustrm_state)
  );

  initial
  begin
    lclk = 1'b0;
    forever #(CLK_PERIOD / 2) lclk = ~lclk;
  end

  ////////////////////
  // Helpers
  ////////////////////

  task automatic raise_failure(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  function automatic row_t make_row(
    input logic [3:0] req, input logic link_up, input logic phy_err, input logic p_act,
    input logic [3:0] sts, input logic [3:0] dstrm, input logic lnk_up, input logic l1,
    input logic [lsm_pkg::LNK_CFG_W-1:0] cfg,
    input logic [lsm_pkg::SPEED_W-1:0] speed, input int lat, input int hold);
    row_t r;
    r.req         = req;
    r.link_up     = link_up;
    r.phy_err     = phy_err;
    r.partner_act = p_act;
    r.sts         = sts;
    r.dstrm       = dstrm;
    r.lnk_up      = lnk_up;
    r.phyinl1     = l1;
    r.cfg         = cfg;
    r.speed       = speed;
    r.lat         = lat;
    r.hold        = hold;
    return r;
  endfunction

  ////////////////////
  // Stimulus table
  ////////////////////

  task automatic fill_table();
    // Held in reset status with the link down
    rows[0] = make_row(lsm_pkg::REQ_NOP, 1'b0, 1'b0, 1'b0,
                       lsm_pkg::STS_RESET, lsm_pkg::SB_NULL, 1'b0, 1'b0,
                       lsm_pkg::LNK_CFG_X1, lsm_pkg::SPEED_GEN1, 0, 0);
    // Cold start passes through one retrain
    rows[1] = make_row(lsm_pkg::REQ_ACTIVE, 1'b1, 1'b0, 1'b0,
                       lsm_pkg::STS_RETRAIN, lsm_pkg::SB_RETRAIN_STS, 1'b1, 1'b0,
                       lsm_pkg::LNK_CFG_X1, lsm_pkg::SPEED_GEN1, 0, 0);
    rows[2] = make_row(lsm_pkg::REQ_ACTIVE, 1'b1, 1'b0, 1'b0,
                       lsm_pkg::STS_ACTIVE, lsm_pkg::SB_ACTIVE_STS, 1'b1, 1'b0,
                       lsm_pkg::LNK_CFG_X16, lsm_pkg::SPEED_GEN5, 0, 0);
    // L1 entry and exit
    rows[3] = make_row(lsm_pkg::REQ_IDLE_L1, 1'b1, 1'b0, 1'b0,
                       lsm_pkg::STS_IDLE_L1, lsm_pkg::SB_L1_STS, 1'b1, 1'b1,
                       lsm_pkg::LNK_CFG_X16, lsm_pkg::SPEED_GEN5, 0, 0);
    rows[4] = make_row(lsm_pkg::REQ_ACTIVE, 1'b1, 1'b0, 1'b0,
                       lsm_pkg::STS_ACTIVE, lsm_pkg::SB_ACTIVE_STS, 1'b1, 1'b0,
                       lsm_pkg::LNK_CFG_X16, lsm_pkg::SPEED_GEN5, 0, 0);
    // Link reset, then the partner asks for active
    rows[5] = make_row(lsm_pkg::REQ_LINK_RESET, 1'b1, 1'b0, 1'b0,
                       lsm_pkg::STS_LINK_RESET, lsm_pkg::SB_LINK_RESET_STS, 1'b0, 1'b0,
                       lsm_pkg::LNK_CFG_X16, lsm_pkg::SPEED_GEN5, 0, 0);
    rows[6] = make_row(lsm_pkg::REQ_LINK_RESET, 1'b1, 1'b0, 1'b1,
                       lsm_pkg::STS_RESET, lsm_pkg::SB_ACTIVE_STS, 1'b0, 1'b0,
                       lsm_pkg::LNK_CFG_X16, lsm_pkg::SPEED_GEN5, 0, 0);
    // Phy error one edge away, then sticky
    rows[7] = make_row(lsm_pkg::REQ_ACTIVE, 1'b1, 1'b1, 1'b0,
                       lsm_pkg::STS_LINK_ERROR, lsm_pkg::SB_LINK_ERROR, 1'b0, 1'b0,
                       lsm_pkg::LNK_CFG_X16, lsm_pkg::SPEED_GEN5, 1, 0);
    rows[8] = make_row(lsm_pkg::REQ_ACTIVE, 1'b1, 1'b0, 1'b0,
                       lsm_pkg::STS_LINK_ERROR, lsm_pkg::SB_LINK_ERROR, 1'b0, 1'b0,
                       lsm_pkg::LNK_CFG_X16, lsm_pkg::SPEED_GEN5, 0, HOLD_MAX);
  endtask

  ////////////////////
  // Checks
  ////////////////////

  task automatic check_reset_outputs();
    assert (!pl_exit_cg_req && !pl_stallreq && !pl_wake_ack && !pl_phyinl1 &&
            !pl_phyinrecenter && !lsm_state_active) else
      raise_failure($sformatf("mismatch at %0t: control outputs not idle after reset", $time));
  endtask

  task automatic run_row(input int r);
    row_t row;
    int   n;
    row = rows[r];
    @(posedge lclk);
    lp_state_req <= row.req;
    ctl_link_up  <= row.link_up;
    ctl_phy_err  <= row.phy_err;
    partner_act  <= row.partner_act;
    // n counts the edges since the row was applied
    n = 0;
    @(negedge lclk);
    while (pl_state_sts != row.sts && n < ROW_TIMEOUT)
    begin
      @(negedge lclk);
      n++;
    end
    assert (pl_state_sts == row.sts) else
      raise_failure($sformatf("row %0d: status %h was not reached within %0d cycles",
                              r, row.sts, ROW_TIMEOUT));
    if (row.lat != 0)
    begin
      assert (n == row.lat && lsm_dstrm_state != row.dstrm) else
        raise_failure($sformatf("mismatch at %0t: row %0d status after %0d edges, expected %0d",
                                $time, r, n, row.lat));
    end
    @(negedge lclk);
    assert (pl_state_sts == row.sts && lsm_dstrm_state == row.dstrm &&
            pl_lnk_up == row.lnk_up && pl_phyinl1 == row.phyinl1 &&
            lsm_state_active == (row.sts == lsm_pkg::STS_ACTIVE)) else
      raise_failure($sformatf("mismatch at %0t: row %0d sts %h/%h dstrm %h/%h up %b/%b l1 %b/%b",
                              $time, r, pl_state_sts, row.sts, lsm_dstrm_state, row.dstrm,
                              pl_lnk_up, row.lnk_up, pl_phyinl1, row.phyinl1));
    assert (lsm_lnk_cfg == row.cfg && lsm_speedmode == row.speed) else
      raise_failure($sformatf("mismatch at %0t: row %0d cfg %0d/%0d speed %0d/%0d",
                              $time, r, lsm_lnk_cfg, row.cfg, lsm_speedmode, row.speed));
    repeat (row.hold)
    begin
      @(negedge lclk);
      assert (pl_state_sts == row.sts && lsm_dstrm_state == row.dstrm) else
        raise_failure($sformatf("mismatch at %0t: row %0d status did not persist", $time, r));
    end
  endtask

  // Ack must follow the request through the synchronizer
  task automatic check_wake(input logic level);
    int n;
    @(posedge lclk);
    lp_wake_req <= level;
    n = 0;
    @(negedge lclk);
    while (pl_wake_ack != level && n < 10)
    begin
      @(negedge lclk);
      n++;
    end
    assert (pl_wake_ack == level && n == lsm_pkg::WAKE_SYNC_STAGES + 1) else
      raise_failure($sformatf("mismatch at %0t: wake ack %b after %0d edges, expected %0d",
                              $time, pl_wake_ack, n, lsm_pkg::WAKE_SYNC_STAGES + 1));
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial
  begin
    rst_n        <= 1'b0;
    lp_state_req <= lsm_pkg::REQ_NOP;
    ctl_link_up  <= 1'b0;
    ctl_phy_err  <= 1'b0;
    lp_wake_req  <= 1'b0;
    partner_act  <= 1'b0;
    fill_table();
    repeat (2) @(posedge lclk);
    rst_n <= 1'b1;
    @(negedge lclk);
    check_reset_outputs();
    for (int r = 0; r < NUM_ROWS; r++)
      run_row(r);
    check_wake(1'b1);
    check_wake(1'b0);
    $display("TESTS PASSED");
    $finish;
  end

  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("TESTS FAILED");
    $fatal(1);
  end

endmodule
